// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dcache.f ====
+incdir+src
src/lsu_pkg.sv
src/dcache_pkg.sv
src/dcache_array.sv
src/dcache_ctrl.sv
src/load_extract.sv
src/store_merge.sv
src/dcache_top.sv
tests/dcache_tb.sv

// ==== src/dcache_array.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_array (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`DC_ADDR_W-1:0]   addr,
	input  logic                    wr_en,
	input  logic [`DC_LINE_W/8-1:0] wr_mask,
	input  logic [`DC_LINE_W-1:0]   wr_line,
	input  logic                    fill_en,
	input  logic [`DC_LINE_W-1:0]   fill_line,
	input  logic                    clean_victim,
	input  logic                    inval,
	input  logic [`DC_ADDR_W-1:0]   inval_addr,
	output logic                    hit,
	output logic [`DC_LINE_W-1:0]   hit_line,
	output logic                    victim_dirty,
	output logic [`DC_ADDR_W-1:0]   victim_addr,
	output logic [`DC_LINE_W-1:0]   victim_line
);
	import dcache_pkg::*;

	logic [`DC_TAG_W-1:0]   tags  [2][`DC_SETS];
	logic [`DC_LINE_W-1:0]  lines [2][`DC_SETS];
	logic [`DC_SETS-1:0]    valid [2];
	logic [`DC_SETS-1:0]    dirty [2];
	logic [`DC_SETS-1:0]    lru;	// way to evict next in each set

	logic [`DC_INDEX_W-1:0] index;
	logic [`DC_INDEX_W-1:0] inval_index;
	logic [`DC_TAG_W-1:0]   tag;
	logic [`DC_TAG_W-1:0]   inval_tag;
	logic [1:0]             way_hit;
	way_t                   hit_way;
	way_t                   victim_way;

	assign index       = addr[`DC_OFFSET_W +: `DC_INDEX_W];
	assign tag         = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign inval_index = inval_addr[`DC_OFFSET_W +: `DC_INDEX_W];
	assign inval_tag   = inval_addr[`DC_ADDR_W-1 -: `DC_TAG_W];

	// tag compare in both ways
	assign way_hit[0] = valid[0][index] && (tags[0][index] == tag);
	assign way_hit[1] = valid[1][index] && (tags[1][index] == tag);
	assign hit        = |way_hit;
	assign hit_way    = way_hit[1] ? WAY1 : WAY0;
	assign hit_line   = lines[hit_way][index];

	// an invalid LRU victim is never written back
	assign victim_way   = way_t'(lru[index]);
	assign victim_dirty = valid[victim_way][index] && dirty[victim_way][index];
	assign victim_addr  = {tags[victim_way][index], index, {`DC_OFFSET_W{1'b0}}};
	assign victim_line  = lines[victim_way][index];

	// valid, dirty and lru bits
	always_ff @(posedge clk) begin
		if (reset) begin
			valid[0] <= '0;
			valid[1] <= '0;
			dirty[0] <= '0;
			dirty[1] <= '0;
			lru      <= '0;	// way0 goes first
		end else begin
			if (inval) begin
				if (tags[0][inval_index] == inval_tag)
					valid[0][inval_index] <= 1'b0;	// dropped without write-back
				if (tags[1][inval_index] == inval_tag)
					valid[1][inval_index] <= 1'b0;
			end
			if (wr_en)
				dirty[hit_way][index] <= 1'b1;
			if (clean_victim)
				dirty[victim_way][index] <= 1'b0;
			// refill comes last so it wins over an invalidate on the same line
			if (fill_en) begin
				valid[victim_way][index] <= 1'b1;
				dirty[victim_way][index] <= 1'b0;
				lru[index]               <= ~lru[index];
			end
		end
	end

	// tags and line data
	always_ff @(posedge clk) begin
		if (fill_en) begin
			lines[victim_way][index] <= fill_line;
			tags[victim_way][index]  <= tag;
		end else if (wr_en) begin
			for (int b = 0; b < `DC_LINE_W/8; b++) begin
				if (wr_mask[b])
					lines[hit_way][index][8*b +: 8] <= wr_line[8*b +: 8];	// byte merge
			end
		end
	end

	// store merge and refill come from different controller states
	a_no_wr_fill: assert property (@(posedge clk) disable iff (reset)
		!(wr_en && fill_en));

endmodule

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  mem_read,
	input  logic                  mem_write,
	input  logic                  hit,
	input  logic                  victim_dirty,
	input  logic                  wb_done,
	input  logic                  fill_done,
	input  logic [3:0]            store_size,
	input  logic [`DC_ADDR_W-1:0] addr,
	input  logic [`DC_WORD_W-1:0] store_word,
	output logic                  stall,
	output logic                  wr_en,
	output logic                  fill_en,
	output logic                  clean_victim,
	output logic                  wb_req,
	output logic                  fill_req,
	output logic                  pending_write,
	output logic [`DC_WORD_W-1:0] pending_data,
	output logic [`DC_ADDR_W-1:0] pending_addr,
	output logic [3:0]            pending_size,
	output logic                  load_valid
);
	import dcache_pkg::*;

	dc_state_t state;
	dc_state_t state_next;
	logic      req;
	logic      in_lookup;
	logic      miss;

	assign req       = mem_read || mem_write;
	assign in_lookup = (state == DC_LOOKUP);
	assign miss      = in_lookup && req && !hit;
	assign stall     = !in_lookup || miss;	// raised in the lookup cycle itself

	always_comb begin
		state_next = state;
		case (state)
			DC_LOOKUP: begin
				if (miss)
					state_next = victim_dirty ? DC_WRITE_BACK : DC_REFILL;
			end
			DC_WRITE_BACK: begin
				if (wb_done)
					state_next = DC_REFILL;
			end
			DC_REFILL: begin
				if (fill_done)
					state_next = DC_LOOKUP;	// access retries as a hit
			end
			default: state_next = DC_LOOKUP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= DC_LOOKUP;
		else
			state <= state_next;
	end

	// request levels held until the memory answers
	assign wb_req       = (state == DC_WRITE_BACK);
	assign fill_req     = (state == DC_REFILL);
	assign clean_victim = wb_req && wb_done;
	assign fill_en      = fill_req && fill_done;
	assign wr_en        = in_lookup && mem_write && hit;
	assign load_valid   = in_lookup && mem_read && hit;

	// write-through notice one cycle after the store edge
	always_ff @(posedge clk) begin
		if (reset)
			pending_write <= 1'b0;
		else
			pending_write <= wr_en;
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			pending_data <= store_word;
			pending_addr <= addr;
			pending_size <= store_size;
		end
	end

	// memory answers only a request that is up
	a_wb_done_req: assert property (@(posedge clk) disable iff (reset)
		wb_done |-> wb_req);

	a_fill_done_req: assert property (@(posedge clk) disable iff (reset)
		fill_done |-> fill_req);

	// requester holds the access while stalled
	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		stall |=> ($stable(mem_read) && $stable(mem_write) && $stable(addr)));

endmodule

// ==== src/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and data widths
`define DC_ADDR_W 64
`define DC_WORD_W 64

// address split into tag | index | offset
`define DC_OFFSET_W 6
`define DC_INDEX_W 6
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

// geometry
`define DC_SETS 64
`define DC_LINE_W 512

`endif

// ==== src/dcache_pkg.sv ====
package dcache_pkg;

	// miss handling states
	typedef enum logic [1:0] {
		DC_LOOKUP     = 2'd0,
		DC_WRITE_BACK = 2'd1,
		DC_REFILL     = 2'd2
	} dc_state_t;

	// way select within a set
	typedef enum logic {
		WAY0 = 1'b0,
		WAY1 = 1'b1
	} way_t;

endpackage

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  mem_read,
	input  logic                  mem_write,
	input  logic [`DC_ADDR_W-1:0] addr,
	input  lsu_pkg::load_op_t     load_op,
	input  lsu_pkg::store_op_t    store_op,
	input  logic [`DC_WORD_W-1:0] store_data,
	input  logic                  inval,
	input  logic [`DC_ADDR_W-1:0] inval_addr,
	input  logic                  wb_done,
	input  logic                  fill_done,
	input  logic [`DC_LINE_W-1:0] fill_line,
	output logic                  stall,
	output logic [`DC_WORD_W-1:0] read_data,
	output logic                  wb_req,
	output logic [`DC_ADDR_W-1:0] wb_addr,
	output logic [`DC_LINE_W-1:0] wb_line,
	output logic                  fill_req,
	output logic [`DC_ADDR_W-1:0] fill_addr,
	output logic                  pending_write,
	output logic [`DC_WORD_W-1:0] pending_data,
	output logic [`DC_ADDR_W-1:0] pending_addr,
	output logic [3:0]            pending_size
);
	logic                    hit;
	logic [`DC_LINE_W-1:0]   hit_line;
	logic                    victim_dirty;
	logic                    wr_en;
	logic                    fill_en;
	logic                    clean_victim;
	logic                    load_valid;
	logic [`DC_LINE_W-1:0]   wr_line;
	logic [`DC_LINE_W/8-1:0] wr_mask;
	logic [`DC_WORD_W-1:0]   store_word;
	logic [3:0]              store_size;
	logic [`DC_WORD_W-1:0]   load_word;

	assign fill_addr = {addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

	dcache_array array_i (
		.clk(clk), .reset(reset), .addr(addr),
		.wr_en(wr_en), .wr_mask(wr_mask), .wr_line(wr_line),
		.fill_en(fill_en), .fill_line(fill_line), .clean_victim(clean_victim),
		.inval(inval), .inval_addr(inval_addr),
		.hit(hit), .hit_line(hit_line), .victim_dirty(victim_dirty),
		.victim_addr(wb_addr), .victim_line(wb_line)
	);

	dcache_ctrl ctrl_i (
		.clk(clk), .reset(reset), .mem_read(mem_read), .mem_write(mem_write),
		.hit(hit), .victim_dirty(victim_dirty), .wb_done(wb_done), .fill_done(fill_done),
		.store_size(store_size), .addr(addr), .store_word(store_word),
		.stall(stall), .wr_en(wr_en), .fill_en(fill_en), .clean_victim(clean_victim),
		.wb_req(wb_req), .fill_req(fill_req), .pending_write(pending_write),
		.pending_data(pending_data), .pending_addr(pending_addr),
		.pending_size(pending_size), .load_valid(load_valid)
	);

	load_extract load_i (
		.hit_line(hit_line), .offset(addr[`DC_OFFSET_W-1:0]),
		.load_op(load_op), .load_word(load_word)
	);

	store_merge store_i (
		.store_data(store_data), .offset(addr[`DC_OFFSET_W-1:0]), .store_op(store_op),
		.wr_line(wr_line), .wr_mask(wr_mask), .store_word(store_word),
		.store_size(store_size)
	);

	// held until the next load hit
	always_ff @(posedge clk) begin
		if (load_valid)
			read_data <= load_word;
	end

endmodule

// ==== src/load_extract.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module load_extract (
	input  logic [`DC_LINE_W-1:0]   hit_line,
	input  logic [`DC_OFFSET_W-1:0] offset,
	input  lsu_pkg::load_op_t       load_op,
	output logic [`DC_WORD_W-1:0]   load_word
);
	import lsu_pkg::*;

	logic [`DC_LINE_W-1:0] shifted;
	logic [`DC_WORD_W-1:0] raw;

	// addressed byte lands at bit 0
	assign shifted = hit_line >> {offset, 3'b000};
	assign raw     = shifted[`DC_WORD_W-1:0];

	always_comb begin
		case (load_op)
			LD_D:    load_word = raw;
			LB:      load_word = {{56{raw[7]}}, raw[7:0]};
			LH:      load_word = {{48{raw[15]}}, raw[15:0]};
			LW:      load_word = {{32{raw[31]}}, raw[31:0]};
			LBU:     load_word = {56'b0, raw[7:0]};
			LHU:     load_word = {48'b0, raw[15:0]};
			LWU:     load_word = {32'b0, raw[31:0]};
			default: load_word = '0;
		endcase
	end

	// encoding 7 has no load behind it
	always_comb begin
		if (!$isunknown(load_op)) begin
			a_load_op: assert (load_op inside {LD_D, LB, LH, LW, LBU, LHU, LWU});
		end
	end

endmodule

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

	// load opcodes as issued by the pipeline
	typedef enum logic [2:0] {
		LD_D = 3'd0,	// 64-bit
		LB   = 3'd1,	// signed byte
		LH   = 3'd2,	// signed half
		LW   = 3'd3,	// signed word
		LBU  = 3'd4,	// unsigned byte
		LHU  = 3'd5,	// unsigned half
		LWU  = 3'd6	// unsigned word
	} load_op_t;

	// store opcodes
	typedef enum logic [1:0] {
		SD = 2'd0,
		SW = 2'd1,
		SH = 2'd2,
		SB = 2'd3
	} store_op_t;

endpackage

// ==== src/store_merge.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module store_merge (
	input  logic [`DC_WORD_W-1:0]   store_data,
	input  logic [`DC_OFFSET_W-1:0] offset,
	input  lsu_pkg::store_op_t      store_op,
	output logic [`DC_LINE_W-1:0]   wr_line,
	output logic [`DC_LINE_W/8-1:0] wr_mask,
	output logic [`DC_WORD_W-1:0]   store_word,
	output logic [3:0]              store_size
);
	import lsu_pkg::*;

	logic [7:0] byte_en;	// enables for the low 8 bytes

	always_comb begin
		case (store_op)
			SD: begin
				store_word = store_data;
				store_size = 4'd8;
				byte_en    = 8'hff;
			end
			SW: begin
				store_word = {32'b0, store_data[31:0]};
				store_size = 4'd4;
				byte_en    = 8'h0f;
			end
			SH: begin
				store_word = {48'b0, store_data[15:0]};
				store_size = 4'd2;
				byte_en    = 8'h03;
			end
			default: begin	// sb
				store_word = {56'b0, store_data[7:0]};
				store_size = 4'd1;
				byte_en    = 8'h01;
			end
		endcase
	end

	// move bytes and mask to the line offset
	assign wr_line = {{(`DC_LINE_W-`DC_WORD_W){1'b0}}, store_word} << {offset, 3'b000};
	assign wr_mask = {{(`DC_LINE_W/8-8){1'b0}}, byte_en} << offset;

endmodule

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;
	import lsu_pkg::*;

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    mem_read;
	logic                    mem_write;
	logic [`DC_ADDR_W-1:0]   addr;
	load_op_t                load_op;
	store_op_t               store_op;
	logic [`DC_WORD_W-1:0]   store_data;
	logic                    inval;
	logic [`DC_ADDR_W-1:0]   inval_addr;
	logic                    wb_done = 1'b0;
	logic                    fill_done = 1'b0;
	logic [`DC_LINE_W-1:0]   fill_line = '0;
	logic                    stall;
	logic [`DC_WORD_W-1:0]   read_data;
	logic                    wb_req;
	logic [`DC_ADDR_W-1:0]   wb_addr;
	logic [`DC_LINE_W-1:0]   wb_line;
	logic                    fill_req;
	logic [`DC_ADDR_W-1:0]   fill_addr;
	logic                    pending_write;
	logic [`DC_WORD_W-1:0]   pending_data;
	logic [`DC_ADDR_W-1:0]   pending_addr;
	logic [3:0]              pending_size;

	logic [`DC_LINE_W-1:0]   mem [logic [`DC_ADDR_W-1:0]];	// sparse array keyed by line address
	logic [`DC_TAG_W-1:0]    m_tag [2][`DC_SETS];
	logic [`DC_LINE_W-1:0]   m_line [2][`DC_SETS];
	bit                      m_valid [2][`DC_SETS];
	bit                      m_dirty [2][`DC_SETS];
	bit                      m_lru [`DC_SETS];
	logic [`DC_TAG_W-1:0]    tag_list [3];
	load_op_t                load_ops [7];
	store_op_t               store_ops [4];
	bit                      mem_busy = 1'b0;
	int                      mem_wait = 0;
	int                      wb_delay = 0;
	int                      fill_delay = 0;
	bit                      last_wb;
	bit                      last_fill;
	string                   test_name;
	string                   abort_msg;
	int                      test_errors;
	int                      total_errors;
	int                      tests_passed;
	int                      tests_failed;
	event                    abort_ev;

	dcache_top dut_i (
		.clk(clk), .reset(reset), .mem_read(mem_read), .mem_write(mem_write),
		.addr(addr), .load_op(load_op), .store_op(store_op), .store_data(store_data),
		.inval(inval), .inval_addr(inval_addr), .wb_done(wb_done), .fill_done(fill_done),
		.fill_line(fill_line), .stall(stall), .read_data(read_data), .wb_req(wb_req),
		.wb_addr(wb_addr), .wb_line(wb_line), .fill_req(fill_req), .fill_addr(fill_addr),
		.pending_write(pending_write), .pending_data(pending_data),
		.pending_addr(pending_addr), .pending_size(pending_size)
	);

	always #10 clk = ~clk;

	function automatic logic [`DC_LINE_W-1:0] default_line(input logic [`DC_ADDR_W-1:0] la);
		logic [`DC_LINE_W-1:0] line;
		for (int i = 0; i < 8; i++)
			line[64*i +: 64] = (la + 64'(8 * i)) * 64'h9e37_79b9_7f4a_7c15;	// odd multiplier
		return line;
	endfunction

	function automatic logic [`DC_LINE_W-1:0] line_of(input logic [`DC_ADDR_W-1:0] la);
		return mem.exists(la) ? mem[la] : default_line(la);
	endfunction

	function automatic int load_bytes(input load_op_t op);
		case (op)
			LD_D:     return 8;
			LW, LWU:  return 4;
			LH, LHU:  return 2;
			default:  return 1;
		endcase
	endfunction

	function automatic int store_bytes(input store_op_t op);
		return (op == SD) ? 8 : (op == SW) ? 4 : (op == SH) ? 2 : 1;
	endfunction

	function automatic logic [`DC_WORD_W-1:0] expect_load(input logic [`DC_LINE_W-1:0] line,
			input logic [5:0] off, input load_op_t op);
		logic [`DC_WORD_W-1:0] v;
		int                    n;
		v = '0;
		n = load_bytes(op);
		for (int i = 0; i < n; i++)
			v[8*i +: 8] = line[8*(off+i) +: 8];
		if ((op == LB || op == LH || op == LW) && v[8*n-1])
			for (int i = n; i < 8; i++)
				v[8*i +: 8] = 8'hff;	// sign fill
		return v;
	endfunction

	function automatic logic [`DC_ADDR_W-1:0] make_addr(input int t, input int s, input int off);
		return {tag_list[t], 6'(s), 6'(off)};
	endfunction

	task automatic check_value(input string what, input logic [`DC_LINE_W-1:0] expected,
			input logic [`DC_LINE_W-1:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string msg);
		assert (cond) else begin
			$display("[ERROR] %s: %s", test_name, msg);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("PASS %s", test_name);
		end else begin
			tests_failed++;
			$display("FAIL %s (%0d errors)", test_name, test_errors);
		end
		total_errors += test_errors;
	endtask

	task automatic abort_run(input string msg);
		abort_msg = msg;
		-> abort_ev;
		forever @(posedge clk);	// the abort process ends the run
	endtask

	initial begin
		@(abort_ev);
		$display("timeout: %s", abort_msg);
		$display("Test failed");
		$finish;
	end

	// memory side answering after 1 to 6 cycles
	always @(posedge clk) begin
		wb_done   <= 1'b0;
		fill_done <= 1'b0;
		if (reset || !(wb_req || fill_req) || wb_done || fill_done) begin
			mem_busy <= 1'b0;
		end else if (!mem_busy) begin
			mem_busy <= 1'b1;
			mem_wait <= wb_req ? wb_delay : fill_delay;
		end else if (mem_wait == 0) begin
			mem_busy <= 1'b0;
			if (wb_req) begin
				wb_done <= 1'b1;	// model already holds the line
			end else begin
				fill_done <= 1'b1;
				fill_line <= line_of(fill_addr);
			end
		end else begin
			mem_wait <= mem_wait - 1;
		end
	end

	task automatic access(input bit is_store, input logic [`DC_ADDR_W-1:0] a,
			input load_op_t lop, input store_op_t sop, input logic [`DC_WORD_W-1:0] sdata);
		logic [5:0]            set;
		logic [5:0]            off;
		logic [`DC_TAG_W-1:0]  tag;
		logic [`DC_ADDR_W-1:0] la;
		logic [`DC_ADDR_W-1:0] exp_wb_addr;
		logic [`DC_LINE_W-1:0] exp_wb_line;
		logic [`DC_WORD_W-1:0] exp_word;
		bit                    exp_wb;
		bit                    exp_fill;
		bit                    seen_wb;
		bit                    seen_fill;
		int                    w;
		int                    n;
		int                    cycles;
		set = a[11:6];
		off = a[5:0];
		tag = a[`DC_ADDR_W-1:12];
		la  = {a[`DC_ADDR_W-1:6], 6'b0};
		exp_wb      = 1'b0;
		exp_fill    = 1'b0;
		exp_wb_addr = '0;
		exp_wb_line = '0;
		exp_word    = '0;
		if (m_valid[0][set] && m_tag[0][set] == tag) begin
			w = 0;
		end else if (m_valid[1][set] && m_tag[1][set] == tag) begin
			w = 1;
		end else begin
			exp_fill = 1'b1;
			w = m_lru[set];
			if (m_valid[w][set] && m_dirty[w][set]) begin
				exp_wb      = 1'b1;
				exp_wb_addr = {m_tag[w][set], set, 6'b0};
				exp_wb_line = m_line[w][set];
				mem[exp_wb_addr] = exp_wb_line;
			end
			m_line[w][set]  = line_of(la);
			m_tag[w][set]   = tag;
			m_valid[w][set] = 1'b1;
			m_dirty[w][set] = 1'b0;
			m_lru[set]      = !m_lru[set];	// flips on refill only
		end
		if (is_store) begin
			n = store_bytes(sop);
			for (int i = 0; i < n; i++) begin
				m_line[w][set][8*(off+i) +: 8] = sdata[8*i +: 8];
				exp_word[8*i +: 8] = sdata[8*i +: 8];
			end
			m_dirty[w][set] = 1'b1;
		end else begin
			exp_word = expect_load(m_line[w][set], off, lop);
		end
		wb_delay   = $urandom_range(0, 5);
		fill_delay = $urandom_range(0, 5);
		seen_wb    = 1'b0;
		seen_fill  = 1'b0;
		cycles     = 0;
		@(posedge clk);
		mem_read   <= !is_store;
		mem_write  <= is_store;
		addr       <= a;
		load_op    <= lop;
		store_op   <= sop;
		store_data <= sdata;
		@(negedge clk);
		check_true(!pending_write, "pending_write stayed high for more than one cycle");
		check_true(stall == exp_fill, "stall in the lookup cycle did not match hit or miss");
		while (stall && cycles < 200) begin
			if (wb_req && !seen_wb) begin
				seen_wb = 1'b1;
				check_value("wb_addr", 512'(exp_wb_addr), 512'(wb_addr));
				check_value("wb_line", exp_wb_line, wb_line);
			end
			if (fill_req && !seen_fill) begin
				seen_fill = 1'b1;
				check_true(seen_wb || !exp_wb, "fill_req rose before the write-back");
				check_value("fill_addr", 512'(la), 512'(fill_addr));
			end
			@(negedge clk);
			cycles++;
		end
		if (stall)
			abort_run("stall stayed high for 200 cycles while an access waited to finish");
		check_true(seen_wb == exp_wb, "write-back request did not match the expected eviction");
		check_true(seen_fill == exp_fill, "refill request did not match the expected miss");
		last_wb   = seen_wb;
		last_fill = seen_fill;
		@(posedge clk);
		mem_read  <= 1'b0;
		mem_write <= 1'b0;
		@(negedge clk);
		if (is_store) begin
			check_true(pending_write, "no pending_write pulse after a store");
			check_value("pending_data", 512'(exp_word), 512'(pending_data));
			check_value("pending_addr", 512'(a), 512'(pending_addr));
			check_value("pending_size", 512'(n), 512'(pending_size));
		end else begin
			check_true(!pending_write, "pending_write pulsed after a load");
			check_value("read_data", 512'(exp_word), 512'(read_data));
		end
	endtask

	task automatic invalidate(input logic [`DC_ADDR_W-1:0] a);
		logic [5:0] set;
		set = a[11:6];
		for (int w = 0; w < 2; w++)
			if (m_tag[w][set] == a[`DC_ADDR_W-1:12])
				m_valid[w][set] = 1'b0;	// dirty data is dropped
		@(posedge clk);
		inval      <= 1'b1;
		inval_addr <= a;
		@(posedge clk);
		inval <= 1'b0;
	endtask

	initial begin
		int                    kind;
		int                    t;
		int                    s;
		int                    size;
		int                    off;
		logic [`DC_ADDR_W-1:0] a;
		reset      <= 1'b1;
		mem_read   <= 1'b0;
		mem_write  <= 1'b0;
		addr       <= '0;
		load_op    <= LD_D;
		store_op   <= SD;
		store_data <= '0;
		inval      <= 1'b0;
		inval_addr <= '0;
		void'($urandom(32'h21b875c4));
		tag_list  = '{52'h0_0000_0001_2345, 52'h5_a5a5_0000_0077, 52'hc_0ffe_e000_1000};
		load_ops  = '{LD_D, LB, LH, LW, LBU, LHU, LWU};
		store_ops = '{SD, SW, SH, SB};
		for (int i = 0; i < `DC_SETS; i++) begin
			m_valid[0][i] = 1'b0;
			m_valid[1][i] = 1'b0;
			m_dirty[0][i] = 1'b0;
			m_dirty[1][i] = 1'b0;
			m_tag[0][i]   = '0;
			m_tag[1][i]   = '0;
			m_lru[i]      = 1'b0;
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		start_test("reset");
		@(negedge clk);
		check_true(!stall && !wb_req && !fill_req && !pending_write,
			"a handshake output was high after reset");
		end_test();

		start_test("load_miss");
		for (int j = 0; j < 7; j++)
			access(1'b0, make_addr(0, 8 + j, 8 * j), load_ops[j], SD, '0);
		end_test();

		start_test("store_hit");
		a = make_addr(0, 30, 16);
		access(1'b0, a, LD_D, SD, '0);
		for (int i = 0; i < 4; i++) begin
			access(1'b1, a, LD_D, store_ops[i], {$urandom, $urandom});
			for (int j = 0; j < 7; j++)
				access(1'b0, a, load_ops[j], SD, '0);
		end
		end_test();

		start_test("eviction");
		access(1'b0, make_addr(0, 1, 0), LD_D, SD, '0);
		access(1'b0, make_addr(1, 1, 0), LD_D, SD, '0);
		access(1'b1, make_addr(0, 1, 24), LD_D, SD, {$urandom, $urandom});
		access(1'b0, make_addr(2, 1, 8), LW, SD, '0);
		check_true(last_wb, "dirty victim gave no write-back");
		access(1'b0, make_addr(0, 1, 24), LD_D, SD, '0);
		check_true(!last_wb && last_fill, "clean victim was not simply refilled");
		end_test();

		start_test("invalidate");
		a = make_addr(1, 20, 0);
		access(1'b0, a, LD_D, SD, '0);
		access(1'b0, make_addr(2, 20, 0), LD_D, SD, '0);	// lru points back at the first way
		access(1'b1, a, LD_D, SD, {$urandom, $urandom});
		invalidate(a);
		access(1'b0, a, LD_D, SD, '0);
		check_true(!last_wb && last_fill, "invalidated line did not refill without write-back");
		end_test();

		start_test("random");
		for (int k = 0; k < 400; k++) begin
			kind = $urandom_range(0, 99);
			t    = $urandom_range(0, 2);
			s    = 2 + $urandom_range(0, 3);	// 4 sets, 3 tags
			if (kind < 15) begin
				invalidate(make_addr(t, s, 0));
			end else if (kind < 55) begin
				store_op_t sop;
				sop  = store_ops[$urandom_range(0, 3)];
				size = store_bytes(sop);
				off  = $urandom_range(0, 63) & ~(size - 1);
				access(1'b1, make_addr(t, s, off), LD_D, sop, {$urandom, $urandom});
			end else begin
				load_op_t lop;
				lop  = load_ops[$urandom_range(0, 6)];
				size = load_bytes(lop);
				off  = $urandom_range(0, 63) & ~(size - 1);
				access(1'b0, make_addr(t, s, off), lop, SD, '0);
			end
		end
		end_test();

		$display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed,
			total_errors);
		if (tests_failed == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
